// File: tb.f
+incdir+bench
logic/dmm_pkg.sv
logic/spi_port.sv
logic/reg_bank.sv
logic/acq_sequencer.sv
logic/adc_mock.sv
logic/dmm_top.sv
bench/tb_dmm.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_dmm -o tb_dmm_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_dmm_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: bench/spi_host.svh
/*
  SPI master tasks for the testbench, mode 0, msb first.
  A frame is a command byte (bit 7 set for a write, address below)
  followed by 32 data bits, framed by the FPGA chip-select code.
  Included inside the testbench module and drives its spi signals.
*/

`ifndef SPI_HOST_SVH
`define SPI_HOST_SVH

  localparam int SCK_HALF = 5;   // clk cycles per sck phase

  task automatic clk_wait(input int n);
    repeat (n) @(posedge clk);
  endtask

  // one full frame, rx gets the 32 bits seen on sdo in the data phase
  task automatic spi_frame(input logic [7:0] cmd, input reg_word_t tx,
                           output reg_word_t rx);
    logic [39:0] out_bits;
    int          i;
    out_bits = {cmd, tx};
    rx       = '0;
    @(posedge clk);
    spi_cs_vec_i <= CS_FPGA0;
    sck_i        <= 1'b0;
    clk_wait(SCK_HALF);   // let the select pass the synchronizer
    for (i = 39; i >= 0; i--) begin
      sdi_i <= out_bits[i];          // data changes with sck low
      clk_wait(SCK_HALF - 1);
      @(negedge clk);
      if (i < 32)
        rx[i] = sdo_o;               // settled well before the rise
      @(posedge clk);
      sck_i <= 1'b1;
      clk_wait(SCK_HALF);
      sck_i <= 1'b0;
    end
    clk_wait(SCK_HALF);
    spi_cs_vec_i <= CS_DEASSERT;
    sdi_i        <= 1'b0;
    clk_wait(SCK_HALF);   // frame gap
  endtask

  task automatic spi_write(input logic [6:0] addr, input reg_word_t data);
    reg_word_t unused_rx;
    spi_frame({1'b1, addr}, data, unused_rx);
  endtask

  task automatic spi_read(input logic [6:0] addr, output reg_word_t data);
    spi_frame({1'b0, addr}, '0, data);
  endtask

`endif

// File: bench/tb_dmm.sv
/*
  Testbench for the multimeter control FPGA top level.
  Steps through chip-select decoding, SPI register access, mode based
  pin selection and the mocked acquisition sequence. Checks are
  assertions, the run stops at the first error.
*/

module tb_dmm
  import dmm_pkg::*;
();

  logic       clk;
  logic       rst_n_i;
  logic       sa_trig_i;
  logic [3:0] hw_flags_i;
  logic       sck_i;
  logic       sdi_i;
  logic       sdo_o;
  logic [2:0] spi_cs_vec_i;
  logic       spi_glb_clk_o;
  logic       spi_glb_mosi_o;
  logic       spi_4094_strobe_o;
  logic       spi_cs_dac_o;
  logic       spi_cs_iso_o;
  logic       spi_cs_iso2_o;
  logic       spi_4094_oe_o;
  logic [3:0] leds_o;
  logic [7:0] monitor_o;
  logic [1:0] pc_sw_o;
  logic [3:0] azmux_o;
  logic       spi_interrupt_o;

  integer     seed;
  int         seq_n;        // programmed length, 1..4
  int         precharge;    // clk cycles
  int         aperture;     // clk cycles
  seq_entry_t entries [4];

  dmm_top #(
    .SYNC_STAGES(2)
  ) DUT (.*);

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // error handling and checks

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_timeout(input string what);
    $display("TIMEOUT at %0t: %s", $time, what);
    abort_run();
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp,
                          input logic [31:0] got);
    assert (got === exp) else begin
      $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
               $time, name, exp, got);
      abort_run();
    end
  endtask

  `include "spi_host.svh"

  // iso2 has no device behind it
  assert property (@(posedge clk) disable iff (!rst_n_i) spi_cs_iso2_o)
    else begin
      $display("MISMATCH time=%0t signal=spi_cs_iso2_o expected=1 actual=%b",
               $time, spi_cs_iso2_o);
      abort_run();
    end

  // measure valid is a single clk wide
  assert property (@(posedge clk) disable iff (!rst_n_i)
                   (sa_trig_i && spi_interrupt_o) |=> !spi_interrupt_o)
    else begin
      $display("spi_interrupt_o stayed high longer than one clock at %0t", $time);
      abort_run();
    end

  //////////////////////////////////////////////////////////////////////
  // sequencer watching

  // follows n samples cycle by cycle, index order from the entries
  task automatic run_sequence(input int n_samples);
    int         idx;
    int         pre_cnt;
    int         smp_cnt;
    int         seen;
    int         guard;
    logic       exp_valid;
    seq_entry_t e;
    idx = 0;
    pre_cnt = 0;
    smp_cnt = 0;
    seen = 0;
    guard = 0;
    while (seen < n_samples) begin
      @(negedge clk);
      guard++;
      if (guard > 1000)
        fail_timeout($sformatf("sequencer gave %0d of %0d samples", seen, n_samples));
      e = entries[idx];
      if (leds_o == 4'd0) begin
        check_eq("azmux_o", 32'd0, 32'(azmux_o));   // idle or sync delay
        check_eq("spi_interrupt_o", 32'd0, 32'(spi_interrupt_o));
      end else begin
        check_eq("leds_o", 1 << idx, 32'(leds_o));
        check_eq("azmux_o", 32'(e.azmux), 32'(azmux_o));
        check_eq("monitor_o[1:0]", idx, 32'(monitor_o[1:0]));
        check_eq("monitor_o[7:4]", 32'd0, 32'(monitor_o[7:4]));
        if (!monitor_o[2]) begin               // precharge phase
          check_eq("pc_sw_o", 32'd0, 32'(pc_sw_o));
          check_eq("spi_interrupt_o", 32'd0, 32'(spi_interrupt_o));
          check_eq("monitor_o[3]", 32'd0, 32'(monitor_o[3]));
          pre_cnt++;
        end else begin                         // sample phase
          check_eq("pc_sw_o", 32'(e.pc), 32'(pc_sw_o));
          exp_valid = (smp_cnt == aperture);   // valid after aperture cycles
          check_eq("spi_interrupt_o", 32'(exp_valid), 32'(spi_interrupt_o));
          check_eq("monitor_o[3]", 32'(exp_valid), 32'(monitor_o[3]));
          if (exp_valid) begin
            check_eq("precharge cycles", precharge, pre_cnt);
            seen++;
            idx = (idx + 1) % seq_n;
            pre_cnt = 0;
            smp_cnt = 0;
          end else begin
            smp_cnt++;
          end
        end
      end
    end
  endtask

  task automatic wait_interrupt();
    int guard;
    guard = 0;
    do begin
      @(negedge clk);
      guard++;
      if (guard > 2000)
        fail_timeout("no spi_interrupt pulse from the sequencer");
    end while (!spi_interrupt_o);
  endtask

  task automatic wait_idle();
    int guard;
    guard = 0;
    do begin
      @(negedge clk);
      guard++;
      if (guard > 20)
        fail_timeout("sequencer did not go idle after the trigger dropped");
    end while (leds_o != 4'd0 || azmux_o != 4'd0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin : main_flow
    reg_word_t  rnd;
    reg_word_t  rd;
    reg_word_t  dir;
    logic [6:0] rw_addr [8];
    int         code;
    int         k;
    logic       exp_clk;
    logic       exp_mosi;

    seed         = 11105;
    clk          = 1'b0;
    rst_n_i      = 1'b0;
    sa_trig_i    = 1'b0;
    hw_flags_i   = 4'd0;
    sck_i        = 1'b0;
    sdi_i        = 1'b0;
    spi_cs_vec_i = CS_DEASSERT;
    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);

    // reset values, nothing written yet
    check_eq("leds_o", 32'd0, 32'(leds_o));
    check_eq("monitor_o", 32'd0, 32'(monitor_o));
    check_eq("pc_sw_o", 32'd0, 32'(pc_sw_o));
    check_eq("azmux_o", 32'd0, 32'(azmux_o));
    check_eq("spi_interrupt_o", 32'd0, 32'(spi_interrupt_o));
    check_eq("spi_4094_oe_o", 32'd0, 32'(spi_4094_oe_o));
    check_eq("sdo_o", 32'd0, 32'(sdo_o));

    // chip-select decode and line parking
    for (code = 0; code < 5; code++) begin
      for (k = 0; k < 2; k++) begin
        @(posedge clk);
        spi_cs_vec_i <= 3'(code);
        sck_i        <= 1'(k);     // both levels on each line
        sdi_i        <= ~1'(k);
        @(negedge clk);
        exp_clk  = (3'(code) == CS_FPGA0) ? 1'b1 : 1'(k);
        exp_mosi = (3'(code) == CS_FPGA0) ? 1'b1 : ~1'(k);
        check_eq("spi_4094_strobe_o", 32'(3'(code) == CS_4094), 32'(spi_4094_strobe_o));
        check_eq("spi_cs_dac_o", 32'(3'(code) != CS_MDAC0), 32'(spi_cs_dac_o));
        check_eq("spi_cs_iso_o", 32'(3'(code) != CS_MDAC1), 32'(spi_cs_iso_o));
        check_eq("spi_glb_clk_o", 32'(exp_clk), 32'(spi_glb_clk_o));
        check_eq("spi_glb_mosi_o", 32'(exp_mosi), 32'(spi_glb_mosi_o));
      end
    end
    @(posedge clk);
    spi_cs_vec_i <= CS_DEASSERT;
    sck_i        <= 1'b0;
    sdi_i        <= 1'b0;
    clk_wait(6);

    // status word
    rnd = $random(seed);
    @(posedge clk);
    hw_flags_i <= rnd[3:0];
    spi_read(REG_STATUS, rd);
    check_eq("status[7:0]", 32'hAA, 32'(rd[7:0]));
    check_eq("status[11:8]", 32'(rnd[3:0]), 32'(rd[11:8]));

    // writable registers read back unchanged
    rw_addr = '{REG_DIRECT, REG_SA_PRECHARGE, REG_ADC_APERTURE, REG_SA_SEQ_N,
                REG_SA_SEQ0, 7'd7, 7'd8, REG_SA_SEQ3};
    for (k = 0; k < 8; k++) begin
      rnd = $random(seed);
      spi_write(rw_addr[k], rnd);
      spi_read(rw_addr[k], rd);
      check_eq($sformatf("reg %0d", rw_addr[k]), rnd, rd);
    end
    spi_read(7'd11, rd);
    check_eq("reg 11", 32'd0, rd);
    spi_read(7'd100, rd);
    check_eq("reg 100", 32'd0, rd);
    spi_write(REG_4094_OE, 32'd1);
    @(negedge clk);
    check_eq("spi_4094_oe_o", 32'd1, 32'(spi_4094_oe_o));

    // direct mode, fields from the low end of the register
    dir = $random(seed);
    spi_write(REG_DIRECT, dir);
    @(negedge clk);
    check_eq("leds_o", 32'(dir[3:0]), 32'(leds_o));
    check_eq("monitor_o", 32'(dir[11:4]), 32'(monitor_o));
    check_eq("pc_sw_o", 32'(dir[13:12]), 32'(pc_sw_o));
    check_eq("azmux_o", 32'(dir[17:14]), 32'(azmux_o));
    check_eq("spi_interrupt_o", 32'(dir[18]), 32'(spi_interrupt_o));
    spi_write(REG_MODE, 32'd3);   // unused mode
    @(negedge clk);
    check_eq("leds_o", 32'd0, 32'(leds_o));
    check_eq("monitor_o", 32'd0, 32'(monitor_o));
    check_eq("pc_sw_o", 32'd0, 32'(pc_sw_o));
    check_eq("azmux_o", 32'd0, 32'(azmux_o));
    check_eq("spi_interrupt_o", 32'd0, 32'(spi_interrupt_o));

    // short sequence, watched cycle by cycle
    rnd       = $random(seed);
    seq_n     = 1 + int'(rnd[1:0]);
    precharge = 2 + int'(rnd[3:2]);
    aperture  = 3 + int'(rnd[5:4]);
    for (k = 0; k < 4; k++) begin
      rnd        = $random(seed);
      entries[k] = seq_entry_t'(rnd[5:0]);
      spi_write(REG_SA_SEQ0 + 7'(k), rnd);
    end
    spi_write(REG_SA_PRECHARGE, 32'(precharge));
    spi_write(REG_ADC_APERTURE, 32'(aperture));
    spi_write(REG_SA_SEQ_N, 32'(seq_n));
    spi_write(REG_MODE, 32'(MODE_SEQ_MOCK));
    @(posedge clk);
    sa_trig_i <= 1'b1;
    run_sequence(2 * seq_n);   // twice round, covers the wrap

    // long entries so a status read ends before the next sample
    @(posedge clk);
    sa_trig_i <= 1'b0;
    wait_idle();
    precharge = 500;
    aperture  = 100;
    spi_write(REG_SA_PRECHARGE, 32'(precharge));
    spi_write(REG_ADC_APERTURE, 32'(aperture));
    @(posedge clk);
    sa_trig_i <= 1'b1;
    for (k = 0; k <= seq_n; k++) begin
      wait_interrupt();
      spi_read(REG_STATUS, rd);
      check_eq("status[7:0]", 32'hAA, 32'(rd[7:0]));
      check_eq("status[17:16]", k % seq_n, 32'(rd[17:16]));
      check_eq("status[22:20]", seq_n, 32'(rd[22:20]));
    end
    @(posedge clk);
    sa_trig_i <= 1'b0;
    wait_idle();
    check_eq("monitor_o", 32'd0, 32'(monitor_o));
    check_eq("pc_sw_o", 32'd0, 32'(pc_sw_o));
    check_eq("spi_interrupt_o", 32'd0, 32'(spi_interrupt_o));

    $display("Verification passed");
    $finish;
  end

endmodule

// File: logic/dmm_top.sv
/*
  Top level of the multimeter control FPGA.
  Connects the SPI port, register bank, acquisition sequencer and ADC
  mock, and spreads the selected pin bundle onto the board outputs.
*/

module dmm_top
  import dmm_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       sa_trig_i,
  input  logic [3:0] hw_flags_i,
  // spi
  input  logic       sck_i,
  input  logic       sdi_i,
  output logic       sdo_o,
  input  logic [2:0] spi_cs_vec_i,
  output logic       spi_glb_clk_o,
  output logic       spi_glb_mosi_o,
  output logic       spi_4094_strobe_o,
  output logic       spi_cs_dac_o,
  output logic       spi_cs_iso_o,
  output logic       spi_cs_iso2_o,
  // board
  output logic       spi_4094_oe_o,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic       spi_interrupt_o
);

  logic        wr_stb;
  logic [6:0]  addr;
  reg_word_t   wdata;
  reg_word_t   rdata;
  seq_cfg_t    seq_cfg;
  reg_word_t   aperture;
  pin_bundle_t seq_pins;
  pin_bundle_t pins;
  logic [1:0]  sample_idx_last;
  logic        adc_reset_n;
  logic        meas_valid;

  spi_port #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_spi_port (
    .clk, .rst_n_i, .sck_i, .sdi_i, .spi_cs_vec_i,
    .rdata_i(rdata),
    .spi_glb_clk_o, .spi_glb_mosi_o, .spi_4094_strobe_o,
    .spi_cs_dac_o, .spi_cs_iso_o, .spi_cs_iso2_o, .sdo_o,
    .wr_stb_o(wr_stb),
    .addr_o(addr),
    .wdata_o(wdata)
  );

  reg_bank u_reg_bank (
    .clk, .rst_n_i, .hw_flags_i, .spi_4094_oe_o,
    .wr_stb_i(wr_stb),
    .addr_i(addr),
    .wdata_i(wdata),
    .sample_idx_last_i(sample_idx_last),
    .seq_pins_i(seq_pins),
    .rdata_o(rdata),
    .seq_cfg_o(seq_cfg),
    .aperture_o(aperture),
    .pins_o(pins)
  );

  acq_sequencer u_acq_sequencer (
    .clk, .rst_n_i, .sa_trig_i,
    .cfg_i(seq_cfg),
    .meas_valid_i(meas_valid),          // fan in from adc mock
    .pins_o(seq_pins),
    .adc_reset_n_o(adc_reset_n),
    .sample_idx_last_o(sample_idx_last)
  );

  adc_mock u_adc_mock (
    .clk, .rst_n_i,
    .adc_reset_n_i(adc_reset_n),
    .aperture_i(aperture),
    .meas_valid_o(meas_valid)
  );

  // bundle onto pins, spare bit goes nowhere
  assign leds_o          = pins.leds;
  assign monitor_o       = pins.monitor;
  assign pc_sw_o         = pins.pc_sw;
  assign azmux_o         = pins.azmux;
  assign spi_interrupt_o = pins.spi_interrupt;

endmodule

// File: logic/adc_mock.sv
/*
  Stand-in for the ADC during sequencer bring-up.
  Counts clocks once released from reset and raises measure valid for a
  single cycle when the aperture count is reached, then waits for the
  next reset pulse.
*/

module adc_mock
  import dmm_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      adc_reset_n_i,
  input  reg_word_t aperture_i,
  output logic      meas_valid_o
);

  reg_word_t cnt;
  logic      fired;   // one pulse per release

  always_ff @(posedge clk) begin
    if (!rst_n_i || !adc_reset_n_i) begin
      cnt          <= '0;
      fired        <= 1'b0;
      meas_valid_o <= 1'b0;
    end else begin
      meas_valid_o <= 1'b0;
      if (!fired) begin
        cnt <= cnt + 32'd1;
        if (cnt + 32'd1 >= aperture_i) begin   // aperture 0 acts as 1
          meas_valid_o <= 1'b1;
          fired        <= 1'b1;
        end
      end
    end
  end

endmodule

// File: logic/acq_sequencer.sv
/*
  Sample acquisition sequencer.
  While the trigger is high it walks through up to four programmed
  entries. Each entry precharges with its azmux code for a fixed count,
  then closes its pc switch and releases the ADC until measure valid.
  Leds and monitor give the current index and phase.
*/

module acq_sequencer
  import dmm_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        sa_trig_i,
  input  seq_cfg_t    cfg_i,
  input  logic        meas_valid_i,
  output pin_bundle_t pins_o,
  output logic        adc_reset_n_o,
  output logic [1:0]  sample_idx_last_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PRECHARGE,
    ST_SAMPLE
  } state_t;

  state_t     state;
  logic [1:0] trig_sr;     // trigger sync
  logic       trig_s;
  logic [23:0] cnt;
  logic [1:0] idx;
  logic [1:0] idx_wrap;    // last valid index
  seq_entry_t entry;

  assign trig_s = trig_sr[1];
  assign entry  = cfg_i.seq[idx];

  // len 0 runs as 1, anything past 4 runs as 4
  always_comb begin
    if (cfg_i.seq_n == 3'd0)
      idx_wrap = 2'd0;
    else if (cfg_i.seq_n > 3'd4)
      idx_wrap = 2'd3;
    else
      idx_wrap = 2'(cfg_i.seq_n - 3'd1);
  end

  //////////////////////////////////////////////////////////////////////
  // state machine

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      trig_sr           <= '0;
      state             <= ST_IDLE;
      cnt               <= '0;
      idx               <= '0;
      sample_idx_last_o <= '0;
    end else begin
      trig_sr <= {trig_sr[0], sa_trig_i};
      if (!trig_s) begin
        state             <= ST_IDLE;   // held off
        cnt               <= '0;
        idx               <= '0;
        sample_idx_last_o <= '0;
      end else begin
        case (state)
          ST_IDLE: begin
            state <= ST_PRECHARGE;
            cnt   <= '0;
          end
          ST_PRECHARGE: begin
            if (cnt + 24'd1 >= cfg_i.precharge)
              state <= ST_SAMPLE;
            else
              cnt <= cnt + 24'd1;
          end
          ST_SAMPLE: begin
            if (meas_valid_i) begin
              sample_idx_last_o <= idx;
              idx   <= (idx == idx_wrap) ? 2'd0 : idx + 2'd1;
              cnt   <= '0;
              state <= ST_PRECHARGE;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs

  always_comb begin
    pins_o        = '0;
    adc_reset_n_o = 1'b0;   // adc held in reset unless sampling
    if (state != ST_IDLE) begin
      pins_o.leds          = 4'b0001 << idx;
      pins_o.monitor       = {4'b0, meas_valid_i, state == ST_SAMPLE, idx};
      pins_o.azmux         = entry.azmux;
      pins_o.spi_interrupt = meas_valid_i;   // tells mcu a sample is ready
      if (state == ST_SAMPLE) begin
        pins_o.pc_sw  = entry.pc;
        adc_reset_n_o = 1'b1;
      end
    end
  end

endmodule

// File: logic/reg_bank.sv
/*
  Register bank behind the SPI port.
  Stores the writable control registers on a write strobe, returns the
  addressed word combinationally for SPI read-back, builds the status
  word, and picks what drives the board pins according to the mode.
*/

module reg_bank
  import dmm_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        wr_stb_i,
  input  logic [6:0]  addr_i,
  input  reg_word_t   wdata_i,
  input  logic [3:0]  hw_flags_i,
  input  logic [1:0]  sample_idx_last_i,
  input  pin_bundle_t seq_pins_i,
  output reg_word_t   rdata_o,
  output logic        spi_4094_oe_o,
  output seq_cfg_t    seq_cfg_o,
  output reg_word_t   aperture_o,
  output pin_bundle_t pins_o
);

  reg_word_t       mode_q;
  reg_word_t       direct_q;
  reg_word_t       oe_q;
  reg_word_t       precharge_q;
  reg_word_t       seq_n_q;
  reg_word_t [3:0] seq_q;
  reg_word_t       aperture_q;
  reg_word_t       status;
  logic [6:0]      seq_off;    // entry offset from REG_SA_SEQ0

  assign seq_off = addr_i - REG_SA_SEQ0;

  //////////////////////////////////////////////////////////////////////
  // writes

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mode_q      <= '0;
      direct_q    <= '0;
      oe_q        <= '0;   // 4094 outputs off at power up
      precharge_q <= '0;
      seq_n_q     <= '0;
      seq_q       <= '0;
      aperture_q  <= '0;
    end else if (wr_stb_i) begin
      case (addr_i)
        REG_MODE:         mode_q      <= wdata_i;
        REG_DIRECT:       direct_q    <= wdata_i;
        REG_4094_OE:      oe_q        <= wdata_i;
        REG_SA_PRECHARGE: precharge_q <= wdata_i;
        REG_SA_SEQ_N:     seq_n_q     <= wdata_i;
        REG_ADC_APERTURE: aperture_q  <= wdata_i;
        default: begin
          if (addr_i >= REG_SA_SEQ0 && addr_i <= REG_SA_SEQ3)
            seq_q[seq_off[1:0]] <= wdata_i;
        end
      endcase
    end
  end

  // status: seq_n 22:20, last idx 17:16, flags 11:8, magic 7:0
  assign status = {9'b0, seq_n_q[2:0], 2'b0, sample_idx_last_i,
                   4'b0, hw_flags_i, STATUS_MAGIC};

  //////////////////////////////////////////////////////////////////////
  // read-back

  always_comb begin
    case (addr_i)
      REG_STATUS:       rdata_o = status;
      REG_MODE:         rdata_o = mode_q;
      REG_DIRECT:       rdata_o = direct_q;
      REG_4094_OE:      rdata_o = oe_q;
      REG_SA_PRECHARGE: rdata_o = precharge_q;
      REG_SA_SEQ_N:     rdata_o = seq_n_q;
      REG_ADC_APERTURE: rdata_o = aperture_q;
      default: begin
        if (addr_i >= REG_SA_SEQ0 && addr_i <= REG_SA_SEQ3)
          rdata_o = seq_q[seq_off[1:0]];
        else
          rdata_o = '0;    // unmapped
      end
    endcase
  end

  // sequencer config, only the low bits of each reg matter
  assign seq_cfg_o.seq_n     = seq_n_q[2:0];
  assign seq_cfg_o.precharge = precharge_q[23:0];
  assign seq_cfg_o.seq[0]    = seq_q[0][5:0];
  assign seq_cfg_o.seq[1]    = seq_q[1][5:0];
  assign seq_cfg_o.seq[2]    = seq_q[2][5:0];
  assign seq_cfg_o.seq[3]    = seq_q[3][5:0];

  assign aperture_o    = aperture_q;
  assign spi_4094_oe_o = oe_q[0];

  //////////////////////////////////////////////////////////////////////
  // pin source by mode

  always_comb begin
    case (mode_q[2:0])
      MODE_DIRECT:   pins_o = pin_bundle_t'(direct_q[19:0]);
      MODE_SEQ_MOCK: pins_o = seq_pins_i;
      default:       pins_o = '0;
    endcase
    pins_o.spare = 1'b0;   // never driven out
  end

endmodule

// File: logic/spi_port.sv
/*
  SPI side of the control FPGA.
  Decodes the chip-select vector onto the device selects and parks the
  shared clock/mosi lines while the FPGA is addressed. For FPGA frames
  it oversamples sck/sdi on clk, collects an 8 bit command and 32 data
  bits, and shifts the addressed register out on sdo (mode 0, msb first).
*/

module spi_port
  import dmm_pkg::*;
#(
  parameter int SYNC_STAGES = 2
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       sck_i,
  input  logic       sdi_i,
  input  logic [2:0] spi_cs_vec_i,
  input  reg_word_t  rdata_i,
  output logic       spi_glb_clk_o,
  output logic       spi_glb_mosi_o,
  output logic       spi_4094_strobe_o,
  output logic       spi_cs_dac_o,
  output logic       spi_cs_iso_o,
  output logic       spi_cs_iso2_o,
  output logic       sdo_o,
  output logic       wr_stb_o,
  output logic [6:0] addr_o,
  output reg_word_t  wdata_o
);

  logic                   cs_fpga;
  logic [SYNC_STAGES-1:0] sck_sr;
  logic [SYNC_STAGES-1:0] sdi_sr;
  logic [SYNC_STAGES-1:0] cs_sr;
  logic                   sck_q;     // last synced sck, for edges
  logic                   sdi_s;
  logic                   cs_s;
  logic                   sck_rise;
  logic                   sck_fall;
  logic [5:0]             bit_cnt;   // 0..40
  logic [7:0]             cmd_q;
  logic                   load_pend;
  reg_word_t              rx_q;
  reg_word_t              tx_q;

  //////////////////////////////////////////////////////////////////////
  // chip-select decode, all combinational

  assign cs_fpga           = (spi_cs_vec_i == CS_FPGA0);
  assign spi_glb_clk_o     = cs_fpga ? 1'b1 : sck_i;   // park hi
  assign spi_glb_mosi_o    = cs_fpga ? 1'b1 : sdi_i;   // park hi
  assign spi_4094_strobe_o = (spi_cs_vec_i == CS_4094); // active hi
  assign spi_cs_dac_o      = (spi_cs_vec_i != CS_MDAC0); // active lo
  assign spi_cs_iso_o      = (spi_cs_vec_i != CS_MDAC1); // active lo
  assign spi_cs_iso2_o     = 1'b1;                     // unused device

  //////////////////////////////////////////////////////////////////////
  // synchronizers

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sck_sr <= '0;
      sdi_sr <= '0;
      cs_sr  <= '0;
      sck_q  <= 1'b0;
    end else begin
      sck_sr <= {sck_sr[SYNC_STAGES-2:0], sck_i};
      sdi_sr <= {sdi_sr[SYNC_STAGES-2:0], sdi_i};
      cs_sr  <= {cs_sr[SYNC_STAGES-2:0], cs_fpga};
      sck_q  <= sck_sr[SYNC_STAGES-1];
    end
  end

  assign sdi_s    = sdi_sr[SYNC_STAGES-1];
  assign cs_s     = cs_sr[SYNC_STAGES-1];
  assign sck_rise = cs_s & sck_sr[SYNC_STAGES-1] & ~sck_q;
  assign sck_fall = cs_s & ~sck_sr[SYNC_STAGES-1] & sck_q;

  //////////////////////////////////////////////////////////////////////
  // framing

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bit_cnt   <= '0;
      cmd_q     <= '0;
      load_pend <= 1'b0;
      tx_q      <= '0;
      wr_stb_o  <= 1'b0;
    end else begin
      wr_stb_o  <= 1'b0;
      load_pend <= 1'b0;
      if (!cs_s) begin
        bit_cnt <= '0;   // frame over or aborted
        tx_q    <= '0;
      end else begin
        if (sck_rise && bit_cnt != 6'd40) begin
          bit_cnt <= bit_cnt + 6'd1;
          if (bit_cnt == 6'd7) begin
            cmd_q     <= {rx_q[6:0], sdi_s};
            load_pend <= 1'b1;     // addr valid next cycle
          end
          if (bit_cnt == 6'd39)
            wr_stb_o <= cmd_q[7];  // write flag
        end
        // load read word, then one bit per falling edge of the data phase
        if (load_pend)
          tx_q <= rdata_i;
        else if (sck_fall && bit_cnt > 6'd8 && bit_cnt < 6'd40)
          tx_q <= {tx_q[30:0], 1'b0};
      end
    end
  end

  // receive shifter and write data
  always_ff @(posedge clk) begin
    if (sck_rise)
      rx_q <= {rx_q[30:0], sdi_s};
    if (sck_rise && bit_cnt == 6'd39)
      wdata_o <= {rx_q[30:0], sdi_s};
  end

  assign addr_o = cmd_q[6:0];
  assign sdo_o  = tx_q[31];

endmodule

// File: logic/dmm_pkg.sv
/*
  Shared definitions for the multimeter control FPGA.
  Holds the SPI chip-select codes, register map, mode codes and the
  packed structs passed between the register bank, the acquisition
  sequencer and the top level. Modules pull it in by wildcard import.
*/

package dmm_pkg;

  //////////////////////////////////////////////////////////////////////
  // spi chip-select vector codes

  localparam logic [2:0] CS_DEASSERT = 3'd0;
  localparam logic [2:0] CS_FPGA0    = 3'd1;  // the register bank itself
  localparam logic [2:0] CS_4094     = 3'd2;
  localparam logic [2:0] CS_MDAC0    = 3'd3;
  localparam logic [2:0] CS_MDAC1    = 3'd4;

  //////////////////////////////////////////////////////////////////////
  // register map, 7 bit address from the command byte

  localparam logic [6:0] REG_STATUS       = 7'd0;  // read only
  localparam logic [6:0] REG_MODE         = 7'd1;
  localparam logic [6:0] REG_DIRECT       = 7'd2;
  localparam logic [6:0] REG_4094_OE      = 7'd3;
  localparam logic [6:0] REG_SA_PRECHARGE = 7'd4;  // clk counts
  localparam logic [6:0] REG_SA_SEQ_N     = 7'd5;
  localparam logic [6:0] REG_SA_SEQ0      = 7'd6;  // seq entries 6..9
  localparam logic [6:0] REG_SA_SEQ3      = 7'd9;
  localparam logic [6:0] REG_ADC_APERTURE = 7'd10;

  // output mode
  localparam logic [2:0] MODE_DIRECT   = 3'd0;
  localparam logic [2:0] MODE_SEQ_MOCK = 3'd6;

  localparam logic [7:0] STATUS_MAGIC = 8'b10101010;

  typedef logic [31:0] reg_word_t;

  // one sequence entry, pc code on top
  typedef struct packed {
    logic [1:0] pc;
    logic [3:0] azmux;
  } seq_entry_t;

  // board outputs, leds at the low end
  typedef struct packed {
    logic       spare;          // always zero
    logic       spi_interrupt;
    logic [3:0] azmux;
    logic [1:0] pc_sw;
    logic [7:0] monitor;
    logic [3:0] leds;
  } pin_bundle_t;

  // sequencer settings, 51 bits
  typedef struct packed {
    logic [2:0]            seq_n;
    logic [23:0]           precharge;
    seq_entry_t [3:0]      seq;
  } seq_cfg_t;

endpackage
